//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = mipsCpuBus_tb
FILELIST = project.f
BUILD    = obj_dir
BINARY   = $(BUILD)/V$(TOP)
SOURCES  = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD)

//--- logic/aluExecute.sv
`include "mips_defines.svh"

module aluExecute (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   executeStrobe,
    input  mipsPkg::decodedInstr   decoded,
    input  logic [`WORD_WIDTH-1:0] regA,
    input  logic [`WORD_WIDTH-1:0] regB,
    input  logic [`WORD_WIDTH-1:0] pcValue,
    output mipsPkg::execResult     result
);
    import mipsPkg::*;

    logic [`WORD_WIDTH-1:0] extImmediate;
    logic [`WORD_WIDTH-1:0] operandB;
    logic [`WORD_WIDTH-1:0] aluValue;
    logic [`WORD_WIDTH-1:0] pcPlus4;
    logic [`WORD_WIDTH-1:0] branchTarget;
    logic [`WORD_WIDTH-1:0] jumpTarget;
    logic                   taken;

    assign extImmediate = decoded.zeroExtend ? {16'b0, decoded.immediate}
                                             : {{16{decoded.immediate[15]}}, decoded.immediate};
    assign operandB = decoded.useImmediate ? extImmediate : regB;

    always_comb begin
        case (decoded.op)
            ALU_ADD:  aluValue = regA + operandB;
            ALU_SUB:  aluValue = regA - operandB;
            ALU_AND:  aluValue = regA & operandB;
            ALU_OR:   aluValue = regA | operandB;
            ALU_XOR:  aluValue = regA ^ operandB;
            ALU_SLT:  aluValue = {31'b0, $signed(regA) < $signed(operandB)};
            ALU_SLTU: aluValue = {31'b0, regA < operandB};
            ALU_SLL:  aluValue = regB << decoded.shamt;   // shifts act on rt
            ALU_SRL:  aluValue = regB >> decoded.shamt;
            ALU_SRA:  aluValue = $signed(regB) >>> decoded.shamt;
            ALU_LUI:  aluValue = {decoded.immediate, 16'b0};
            default:  aluValue = '0;
        endcase
    end

    assign pcPlus4      = pcValue + 32'd4;
    assign branchTarget = pcPlus4 + {{14{decoded.immediate[15]}}, decoded.immediate, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], decoded.jumpIndex, 2'b00};

    always_comb begin
        case (decoded.branch)
            BR_EQUAL:    taken = (regA == regB);
            BR_NOTEQUAL: taken = (regA != regB);
            BR_JUMP:     taken = 1'b1;
            default:     taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (executeStrobe) begin
            result.aluOut     <= aluValue;
            result.takeBranch <= taken;
            result.target     <= decoded.regJump ? regA :
                                 (decoded.branch == BR_JUMP) ? jumpTarget : branchTarget;
        end
    end

endmodule

//--- logic/busSequencer.sv
`include "mips_defines.svh"

module busSequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   waitRequest,
    input  logic [`WORD_WIDTH-1:0] readData,
    input  mipsPkg::decodedInstr   decoded,
    input  mipsPkg::execResult     result,
    input  logic [`WORD_WIDTH-1:0] storeData,
    output logic [`WORD_WIDTH-1:0] instrWord,
    output logic                   executeStrobe,
    output logic                   writebackStrobe,
    output logic [`WORD_WIDTH-1:0] pcValue,
    output logic [`WORD_WIDTH-1:0] address,
    output logic                   read,
    output logic                   write,
    output logic [`WORD_WIDTH-1:0] writeData,
    output logic [3:0]             byteEnable,
    output logic                   active
);
    import mipsPkg::*;

    cpuState                state;
    logic [`WORD_WIDTH-1:0] savedTarget;     // target of the last taken transfer
    logic                   transferPending; // delay slot in progress
    logic                   fetchHalt;
    logic                   memAccess;
    logic [`WORD_WIDTH-1:0] pcPlus4;

    assign fetchHalt = (pcValue == `HALT_ADDRESS);
    assign memAccess = decoded.isLoad || decoded.isStore;
    assign pcPlus4   = pcValue + 32'd4;

    assign executeStrobe   = (state == S_EXECUTE);
    assign writebackStrobe = (state == S_WRITEBACK);

    // avalon master outputs, all derived from registered state
    assign read  = (state == S_FETCH && !fetchHalt) || (state == S_MEMORY && decoded.isLoad);
    assign write = (state == S_MEMORY) && decoded.isStore;
    assign address = (state == S_FETCH) ? pcValue
                                        : {result.aluOut[`WORD_WIDTH-1:2], 2'b00};
    assign writeData  = storeData;                      // rt read port
    assign byteEnable = (read || write) ? 4'b1111 : 4'b0000;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= S_FETCH;
            pcValue         <= `RESET_VECTOR;
            transferPending <= 1'b0;
            active          <= 1'b1;
        end else begin
            case (state)
                S_FETCH: begin
                    if (fetchHalt) begin
                        state  <= S_HALTED;
                        active <= 1'b0;
                    end else if (!waitRequest) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE:  state <= S_EXECUTE;
                S_EXECUTE: state <= S_MEMORY;
                S_MEMORY: begin
                    if (!(memAccess && waitRequest)) begin
                        state <= S_WRITEBACK;
                    end
                end
                S_WRITEBACK: begin
                    state <= S_FETCH;
                    // the delay slot finishes here, so the saved target takes over
                    if (transferPending) begin
                        pcValue <= savedTarget;
                    end else begin
                        pcValue <= pcPlus4;
                    end
                    transferPending <= result.takeBranch;
                end
                S_HALTED:  state <= S_HALTED;  // only reset leaves
                default:   state <= S_HALTED;
            endcase
        end
    end

    // instruction and branch target capture
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            instrWord <= readData;          // data valid the cycle after acceptance
        end
        if (state == S_WRITEBACK && result.takeBranch) begin
            savedTarget <= result.target;
        end
    end

endmodule

//--- logic/instrDecode.sv
`include "mips_defines.svh"

module instrDecode (
    input  logic [`WORD_WIDTH-1:0] instrWord,
    output mipsPkg::decodedInstr   decoded
);
    import mipsPkg::*;

    opCode opField;
    fnCode fnField;

    assign opField = opCode'(instrWord[31:26]);
    assign fnField = fnCode'(instrWord[5:0]);

    always_comb begin
        // raw fields, then a harmless no-op
        decoded.rs           = instrWord[25:21];
        decoded.rt           = instrWord[20:16];
        decoded.shamt        = instrWord[10:6];
        decoded.immediate    = instrWord[15:0];
        decoded.jumpIndex    = instrWord[25:0];
        decoded.op           = ALU_ADD;
        decoded.useImmediate = 1'b1;
        decoded.zeroExtend   = 1'b0;
        decoded.destReg      = instrWord[20:16];  // rt for i-type
        decoded.regWrite     = 1'b0;
        decoded.isLoad       = 1'b0;
        decoded.isStore      = 1'b0;
        decoded.branch       = BR_NONE;
        decoded.isLink       = 1'b0;
        decoded.regJump      = 1'b0;

        case (opField)
            OP_RTYPE: begin
                decoded.useImmediate = 1'b0;
                decoded.destReg      = instrWord[15:11];
                decoded.regWrite     = 1'b1;
                case (fnField)
                    FN_ADDU: decoded.op = ALU_ADD;
                    FN_SUBU: decoded.op = ALU_SUB;
                    FN_AND:  decoded.op = ALU_AND;
                    FN_OR:   decoded.op = ALU_OR;
                    FN_XOR:  decoded.op = ALU_XOR;
                    FN_SLT:  decoded.op = ALU_SLT;
                    FN_SLTU: decoded.op = ALU_SLTU;
                    FN_SLL:  decoded.op = ALU_SLL;
                    FN_SRL:  decoded.op = ALU_SRL;
                    FN_SRA:  decoded.op = ALU_SRA;
                    FN_JR: begin
                        decoded.regWrite = 1'b0;
                        decoded.branch   = BR_JUMP;
                        decoded.regJump  = 1'b1;
                    end
                    default: decoded.regWrite = 1'b0;  // unknown function
                endcase
            end
            OP_ADDIU: decoded.regWrite = 1'b1;
            OP_SLTI: begin
                decoded.op       = ALU_SLT;
                decoded.regWrite = 1'b1;
            end
            OP_SLTIU: begin
                decoded.op       = ALU_SLTU;   // sign-extended, compared unsigned
                decoded.regWrite = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                decoded.op = (opField == OP_ANDI) ? ALU_AND :
                             (opField == OP_ORI)  ? ALU_OR  : ALU_XOR;
                decoded.zeroExtend = 1'b1;
                decoded.regWrite   = 1'b1;
            end
            OP_LUI: begin
                decoded.op       = ALU_LUI;
                decoded.regWrite = 1'b1;
            end
            OP_LW: begin
                decoded.isLoad   = 1'b1;
                decoded.regWrite = 1'b1;
            end
            OP_SW: decoded.isStore = 1'b1;
            OP_BEQ, OP_BNE: begin
                decoded.useImmediate = 1'b0;
                decoded.branch = (opField == OP_BEQ) ? BR_EQUAL : BR_NOTEQUAL;
            end
            OP_J: decoded.branch = BR_JUMP;
            OP_JAL: begin
                decoded.branch   = BR_JUMP;
                decoded.isLink   = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.destReg  = `LINK_REG;
            end
            default: ;  // unsupported opcode runs as a nop
        endcase
    end

endmodule

//--- logic/mipsCpuBus.sv
`include "mips_defines.svh"

module mipsCpuBus (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   active,
    output logic [`WORD_WIDTH-1:0] registerV0,
    output logic [`WORD_WIDTH-1:0] address,
    output logic                   write,
    output logic                   read,
    input  logic                   waitRequest,
    output logic [`WORD_WIDTH-1:0] writeData,
    output logic [3:0]             byteEnable,
    input  logic [`WORD_WIDTH-1:0] readData
);
    import mipsPkg::*;

    decodedInstr decoded;
    execResult   result;

    logic [`WORD_WIDTH-1:0]    instrWord;
    logic [`WORD_WIDTH-1:0]    pcValue;
    logic                      executeStrobe;
    logic                      writebackStrobe;
    logic [`WORD_WIDTH-1:0]    regA;
    logic [`WORD_WIDTH-1:0]    regB;     // also the store data
    logic                      regWriteEnable;
    logic [`REG_ADDR_WIDTH-1:0] regWriteAddress;
    logic [`WORD_WIDTH-1:0]    regWriteValue;

    busSequencer sequencer (
        .clk(clk), .reset(reset),
        .waitRequest(waitRequest), .readData(readData),
        .decoded(decoded), .result(result), .storeData(regB),
        .instrWord(instrWord), .executeStrobe(executeStrobe),
        .writebackStrobe(writebackStrobe), .pcValue(pcValue),
        .address(address), .read(read), .write(write),
        .writeData(writeData), .byteEnable(byteEnable), .active(active)
    );

    instrDecode decoder (.instrWord(instrWord), .decoded(decoded));

    aluExecute alu (
        .clk(clk), .reset(reset), .executeStrobe(executeStrobe),
        .decoded(decoded), .regA(regA), .regB(regB),
        .pcValue(pcValue), .result(result)
    );

    writebackResult writeback (
        .writebackStrobe(writebackStrobe), .decoded(decoded), .result(result),
        .readData(readData), .pcValue(pcValue),
        .writeEnable(regWriteEnable), .writeAddress(regWriteAddress),
        .writeValue(regWriteValue)
    );

    registerFile regs (
        .clk(clk), .reset(reset),
        .readAddressA(decoded.rs), .readAddressB(decoded.rt),
        .readDataA(regA), .readDataB(regB),
        .writeEnable(regWriteEnable), .writeAddress(regWriteAddress),
        .writeValue(regWriteValue), .registerV0(registerV0)
    );

endmodule

//--- logic/mipsPkg.sv
`include "mips_defines.svh"

package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opCode;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } fnCode;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOp;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALTED
    } cpuState;

    typedef enum logic [1:0] {
        BR_NONE, BR_EQUAL, BR_NOTEQUAL, BR_JUMP
    } branchKind;

    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [4:0]                 shamt;
        logic [15:0]                immediate;
        logic [25:0]                jumpIndex;
        aluOp                       op;
        logic                       useImmediate;
        logic                       zeroExtend;     // logical immediates
        logic [`REG_ADDR_WIDTH-1:0] destReg;
        logic                       regWrite;
        logic                       isLoad;
        logic                       isStore;
        branchKind                  branch;
        logic                       isLink;         // writes pc + 8
        logic                       regJump;        // target comes from rs (jr)
    } decodedInstr;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] aluOut;
        logic [`WORD_WIDTH-1:0] target;
        logic                   takeBranch;
    } execResult;

endpackage

//--- logic/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// data path and bus width
`define WORD_WIDTH 32
`define REG_ADDR_WIDTH 5

`define RESET_VECTOR 32'hBFC00000   // first instruction fetch
`define HALT_ADDRESS 32'h00000000   // fetching from here stops the cpu

// fixed register numbers
`define LINK_REG 5'd31              // jal return address
`define V0_REG 5'd2                 // mirrored on registerV0

`endif

//--- logic/registerFile.sv
`include "mips_defines.svh"

module registerFile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddressA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddressB,
    output logic [`WORD_WIDTH-1:0]     readDataA,
    output logic [`WORD_WIDTH-1:0]     readDataB,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddress,
    input  logic [`WORD_WIDTH-1:0]     writeValue,
    output logic [`WORD_WIDTH-1:0]     registerV0
);

    logic [`WORD_WIDTH-1:0] regs [32];

    // asynchronous read ports
    assign readDataA  = regs[readAddressA];
    assign readDataB  = regs[readAddressB];
    assign registerV0 = regs[`V0_REG];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (writeEnable && writeAddress != '0) begin
            regs[writeAddress] <= writeValue;   // $zero stays zero
        end
    end

endmodule

//--- logic/writebackResult.sv
`include "mips_defines.svh"

module writebackResult (
    input  logic                        writebackStrobe,
    input  mipsPkg::decodedInstr        decoded,
    input  mipsPkg::execResult          result,
    input  logic [`WORD_WIDTH-1:0]      readData,
    input  logic [`WORD_WIDTH-1:0]      pcValue,
    output logic                        writeEnable,
    output logic [`REG_ADDR_WIDTH-1:0]  writeAddress,
    output logic [`WORD_WIDTH-1:0]      writeValue
);

    // one pulse per instruction, the sequencer holds writeback for a single cycle
    assign writeEnable  = writebackStrobe && decoded.regWrite;
    assign writeAddress = decoded.destReg;

    always_comb begin
        if (decoded.isLoad) begin
            writeValue = readData;          // load data lands on writeback entry
        end else if (decoded.isLink) begin
            writeValue = pcValue + 32'd8;   // skip the delay slot
        end else begin
            writeValue = result.aluOut;
        end
    end

endmodule

//--- project.f
+incdir+logic
logic/mipsPkg.sv
logic/registerFile.sv
logic/instrDecode.sv
logic/aluExecute.sv
logic/writebackResult.sv
logic/busSequencer.sv
logic/mipsCpuBus.sv
tb/avalonMemory.sv
tb/mipsCpuBus_properties.sv
tb/mipsCpuBus_tb.sv

//--- tb/avalonMemory.sv
`include "mips_defines.svh"

module avalonMemory (
    input  logic                   clk,
    input  int                     stallPercent,   // chance of a stall per cycle
    input  logic [`WORD_WIDTH-1:0] address,
    input  logic                   read,
    input  logic                   write,
    input  logic [`WORD_WIDTH-1:0] writeData,
    input  logic [3:0]             byteEnable,
    output logic                   waitRequest,
    output logic [`WORD_WIDTH-1:0] readData,
    input  logic                   loadEnable,
    input  logic [`WORD_WIDTH-1:0] loadAddress,
    input  logic [`WORD_WIDTH-1:0] loadValue
);

    logic [`WORD_WIDTH-1:0] words [logic [29:0]];   // sparse, keyed by word address
    logic                   stall = 1'b0;
    logic [`WORD_WIDTH-1:0] dataOut = '0;

    assign waitRequest = stall;
    assign readData    = dataOut;

    // unwritten words return a value tied to their address
    function automatic logic [31:0] peekWord(input logic [31:0] byteAddress);
        if (words.exists(byteAddress[31:2])) begin
            return words[byteAddress[31:2]];
        end
        return {byteAddress[29:0], byteAddress[31:30]} ^ 32'hC3A5_5A3C;
    endfunction

    always @(negedge clk) begin
        stall <= (int'($urandom % 100) < stallPercent);
    end

    always @(posedge clk) begin
        if (loadEnable) begin
            words[loadAddress[31:2]] = loadValue;
        end else if (write && !stall && byteEnable == 4'b1111) begin
            words[address[31:2]] = writeData;
        end
        if (read && !stall) begin
            dataOut <= peekWord(address);      // valid one cycle after acceptance
        end
    end

endmodule

//--- tb/mipsCpuBus_properties.sv
`include "mips_defines.svh"

module mipsCpuBus_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   active,
    input logic                   read,
    input logic                   write,
    input logic                   waitRequest,
    input logic [`WORD_WIDTH-1:0] address,
    input logic [`WORD_WIDTH-1:0] writeData
);

    // one bus command at a time
    noDualCommand: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write asserted together");

    holdUnderStall: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitRequest |=> $stable(address) && $stable(read)
            && $stable(write) && $stable(writeData))
        else $error("bus command changed while waitRequest was high");

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus command issued after halt");

endmodule

bind mipsCpuBus mipsCpuBus_properties busChecks (.*);

//--- tb/mipsCpuBus_tb.sv
`include "mips_defines.svh"

module mipsCpuBus_tb;

    // instruction encodings from the MIPS-I reference
    localparam logic [5:0] OP_J = 6'h02, OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05,
                           OP_ADDIU = 6'h09, OP_ORI = 6'h0D, OP_LUI = 6'h0F,
                           OP_LW = 6'h23, OP_SW = 6'h2B;
    localparam logic [5:0] FN_SLL = 6'h00, FN_SRA = 6'h03, FN_JR = 6'h08, FN_ADDU = 6'h21,
                           FN_SUBU = 6'h23, FN_XOR = 6'h26, FN_SLT = 6'h2A, FN_SLTU = 6'h2B;

    logic                   clk;
    logic                   reset;
    logic                   active;
    logic                   read;
    logic                   write;
    logic                   waitRequest;
    logic [`WORD_WIDTH-1:0] registerV0;
    logic [`WORD_WIDTH-1:0] address;
    logic [`WORD_WIDTH-1:0] writeData;
    logic [`WORD_WIDTH-1:0] readData;
    logic [3:0]             byteEnable;

    int                     stallPercent;
    logic                   loadEnable;
    logic [`WORD_WIDTH-1:0] loadAddress;
    logic [`WORD_WIDTH-1:0] loadValue;
    logic [`WORD_WIDTH-1:0] image [$];   // program words, placed at the reset vector
    int                     errorCount;
    int                     checkCount;

    mipsCpuBus UUT (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitRequest(waitRequest),
        .writeData(writeData), .byteEnable(byteEnable), .readData(readData)
    );

    avalonMemory memory (
        .clk(clk), .stallPercent(stallPercent),
        .address(address), .read(read), .write(write), .writeData(writeData),
        .byteEnable(byteEnable), .waitRequest(waitRequest), .readData(readData),
        .loadEnable(loadEnable), .loadAddress(loadAddress), .loadValue(loadValue)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] shamt);
        return {6'b000000, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};   // word index within the 256 MB region
    endfunction

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s got %h expected %h",
                     $time, name, got, expected);
        end
    endtask

    // jr $zero plus a nop in its delay slot
    task automatic appendReturnToZero();
        image.push_back(rType(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        image.push_back(32'h0000_0000);
    endtask

    task automatic runProgram(input int stall);
        int cycles;
        @(negedge clk);
        reset        = 1'b1;
        stallPercent = stall;
        foreach (image[i]) begin
            loadEnable  = 1'b1;
            loadAddress = `RESET_VECTOR + 32'(i * 4);
            loadValue   = image[i];
            @(negedge clk);
        end
        loadEnable = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // first fetch comes straight from the reset vector
        check("active", {31'b0, active}, 32'd1);
        check("read", {31'b0, read}, 32'd1);
        check("write", {31'b0, write}, 32'd0);
        check("address", address, `RESET_VECTOR);
        check("byteEnable", {28'b0, byteEnable}, 32'h0000_000F);
        cycles = 0;
        while (active === 1'b1 && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            errorCount++;
            $display("timeout at time %0t: processor still active after 2000 cycles", $time);
        end
        image.delete();
    endtask

    task automatic aluTest();
        logic [15:0] imm;
        logic [31:0] r8, r9, r10, r11, r12, r13, r14, r15, r16;
        imm = 16'($urandom);
        image.push_back(iType(OP_ADDIU, 5'd8, 5'd0, imm));
        image.push_back(iType(OP_ORI, 5'd9, 5'd0, 16'hF0F0));
        image.push_back(iType(OP_LUI, 5'd10, 5'd0, 16'h8765));
        image.push_back(rType(FN_SUBU, 5'd11, 5'd8, 5'd9, 5'd0));
        image.push_back(rType(FN_XOR, 5'd12, 5'd11, 5'd10, 5'd0));
        image.push_back(rType(FN_SLT, 5'd13, 5'd10, 5'd8, 5'd0));
        image.push_back(rType(FN_SLTU, 5'd14, 5'd10, 5'd8, 5'd0));
        image.push_back(rType(FN_SLL, 5'd15, 5'd0, 5'd12, 5'd4));
        image.push_back(rType(FN_SRA, 5'd16, 5'd0, 5'd10, 5'd8));
        image.push_back(rType(FN_ADDU, 5'd2, 5'd15, 5'd16, 5'd0));
        image.push_back(rType(FN_ADDU, 5'd2, 5'd2, 5'd13, 5'd0));
        image.push_back(rType(FN_ADDU, 5'd2, 5'd2, 5'd14, 5'd0));
        appendReturnToZero();
        runProgram(0);
        r8  = {{16{imm[15]}}, imm};           // addiu sign-extends
        r9  = 32'h0000_F0F0;                  // ori zero-extends
        r10 = 32'h8765_0000;
        r11 = r8 - r9;
        r12 = r11 ^ r10;
        r13 = {31'b0, $signed(r10) < $signed(r8)};
        r14 = {31'b0, r10 < r8};
        r15 = r12 << 4;
        r16 = $signed(r10) >>> 8;
        check("registerV0", registerV0, r15 + r16 + r13 + r14);
    endtask

    task automatic memoryTest();
        logic [31:0] value;
        value = $urandom;
        image.push_back(iType(OP_ADDIU, 5'd8, 5'd0, 16'h1000));
        image.push_back(iType(OP_LUI, 5'd9, 5'd0, value[31:16]));
        image.push_back(iType(OP_ORI, 5'd9, 5'd9, value[15:0]));
        image.push_back(iType(OP_SW, 5'd9, 5'd8, 16'h0004));
        image.push_back(iType(OP_LW, 5'd2, 5'd8, 16'h0004));
        appendReturnToZero();
        runProgram(40);
        check("memory[0x1004]", memory.peekWord(32'h0000_1004), value);
        check("registerV0", registerV0, value);
    endtask

    task automatic controlTest();
        logic [31:0] link;
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd0, 16'h0000));
        image.push_back(iType(OP_BEQ, 5'd0, 5'd0, 16'd2));       // taken, to word 4
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0001));  // delay slot
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0100));  // skipped
        image.push_back(iType(OP_BNE, 5'd0, 5'd0, 16'd2));       // not taken
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0002));
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0004));  // fall through
        image.push_back(jType(OP_J, `RESET_VECTOR + 32'd40));
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0008));
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0200));  // skipped
        image.push_back(jType(OP_JAL, `RESET_VECTOR + 32'd52));
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0010));
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd2, 16'h0400));  // skipped
        image.push_back(rType(FN_ADDU, 5'd2, 5'd31, 5'd2, 5'd0));
        appendReturnToZero();
        runProgram(25);
        link = `RESET_VECTOR + 32'd40 + 32'd8;   // jal sits at word 10
        check("registerV0", registerV0, link + 32'd31);
    endtask

    task automatic haltTest();
        int cycles;
        image.push_back(iType(OP_ADDIU, 5'd2, 5'd0, 16'd7));
        image.push_back(iType(OP_ADDIU, 5'd0, 5'd0, 16'h0055));  // must be dropped
        image.push_back(rType(FN_ADDU, 5'd2, 5'd2, 5'd0, 5'd0));
        appendReturnToZero();
        runProgram(0);
        check("registerV0", registerV0, 32'd7);
        for (cycles = 0; cycles < 50; cycles++) begin
            @(negedge clk);
            check("{read,write,active}", {29'b0, read, write, active}, 32'd0);
        end
    endtask

    initial begin
        void'($urandom(32'h78f3_9c31));
        reset        = 1'b1;
        stallPercent = 0;
        loadEnable   = 1'b0;
        loadAddress  = '0;
        loadValue    = '0;
        errorCount   = 0;
        checkCount   = 0;
        repeat (8) @(negedge clk);
        aluTest();
        memoryTest();
        controlTest();
        haltTest();
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
